/* rd_split_pkg.sv */
// Shared widths, burst encodings and queue depth for the read burst splitter and its testbench
package rd_split_pkg;

  // ------------------------------------------------------------------------
  // Bus field widths
  // ------------------------------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int ID_W    = 4;

  // Burst length field holds beats minus one
  localparam int LEN_W   = 8;

  // Bytes per beat is 1 << size
  localparam int SIZE_W  = 3;

  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // ------------------------------------------------------------------------
  // Burst type encodings
  // ------------------------------------------------------------------------
  localparam logic [BURST_W-1:0] BURST_FIXED = 2'd0;
  localparam logic [BURST_W-1:0] BURST_INCR  = 2'd1;

  // Not supported by the splitter, only used to flag illegal input
  localparam logic [BURST_W-1:0] BURST_WRAP  = 2'd2;

  // ------------------------------------------------------------------------
  // Outstanding burst tracking
  // ------------------------------------------------------------------------
  // Number of bursts that may wait for read data at once
  localparam int MAX_RD_TXNS = 4;

  // Pointer width into the length queue
  localparam int FIFO_IDX_W  = 2;

endpackage

/* ar_split_stage.sv */
// Accepts one upstream read burst and replays it downstream as single-beat read requests
`timescale 1ns/1ps

module ar_split_stage (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Upstream AR
  input  logic [rd_split_pkg::ID_W-1:0]     ar_id_i,
  input  logic [rd_split_pkg::ADDR_W-1:0]   ar_addr_i,
  input  logic [rd_split_pkg::LEN_W-1:0]    ar_len_i,
  input  logic [rd_split_pkg::SIZE_W-1:0]   ar_size_i,
  input  logic [rd_split_pkg::BURST_W-1:0]  ar_burst_i,
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,

  // Downstream single-beat AR
  output logic [rd_split_pkg::ID_W-1:0]     m_ar_id_o,
  output logic [rd_split_pkg::ADDR_W-1:0]   m_ar_addr_o,
  output logic                              m_ar_valid_o,
  input  logic                              m_ar_ready_i,

  // Length queue write side
  input  logic                              fifo_full_i,
  output logic                              push_o,
  output logic [rd_split_pkg::LEN_W-1:0]    push_len_o
);

  // Idle when low, issuing beats when high
  logic                              busy_q;

  // Registered copy of the burst being split
  logic [rd_split_pkg::ID_W-1:0]     id_q;
  logic [rd_split_pkg::ADDR_W-1:0]   addr_q;
  logic [rd_split_pkg::SIZE_W-1:0]   size_q;
  logic [rd_split_pkg::BURST_W-1:0]  burst_q;

  // Beats still to send after the current one
  logic [rd_split_pkg::LEN_W-1:0]    rem_q;

  logic                              accept;
  logic                              beat_done;
  logic [rd_split_pkg::ADDR_W-1:0]   addr_step;

  // New burst only while idle and a length slot is free
  assign ar_ready_o = ~busy_q & ~fifo_full_i;
  assign accept     = ar_valid_i & ar_ready_o;

  // Length goes into the queue together with the acceptance
  assign push_o     = accept;
  assign push_len_o = ar_len_i;

  assign m_ar_valid_o = busy_q;
  assign m_ar_id_o    = id_q;
  assign m_ar_addr_o  = addr_q;

  assign beat_done = busy_q & m_ar_ready_i;
  assign addr_step = rd_split_pkg::ADDR_W'(1) << size_q;

  // ------------------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (beat_done && rem_q == '0) begin
      // Final beat handed over, back to idle next cycle
      busy_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // Burst payload and beat stepping
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q    <= ar_id_i;
      addr_q  <= ar_addr_i;
      size_q  <= ar_size_i;
      burst_q <= ar_burst_i;
      rem_q   <= ar_len_i;
    end else if (beat_done && rem_q != '0) begin
      rem_q <= rem_q - 1'b1;
      // FIXED bursts keep hitting the same address
      if (burst_q == rd_split_pkg::BURST_INCR) begin
        addr_q <= addr_q + addr_step;
      end
    end
  end

endmodule

/* burst_len_fifo.sv */
// In-order queue of outstanding burst lengths, written on AR acceptance and read on R last
`timescale 1ns/1ps

module burst_len_fifo (
  input  logic                            clk_i,
  input  logic                            rst_i,

  input  logic                            push_i,
  input  logic [rd_split_pkg::LEN_W-1:0]  push_len_i,
  input  logic                            pop_i,

  output logic [rd_split_pkg::LEN_W-1:0]  head_len_o,
  output logic                            full_o,
  output logic                            empty_o
);

  logic [rd_split_pkg::LEN_W-1:0]       mem_q [rd_split_pkg::MAX_RD_TXNS];

  logic [rd_split_pkg::FIFO_IDX_W-1:0]  wr_ptr_q;
  logic [rd_split_pkg::FIFO_IDX_W-1:0]  rd_ptr_q;

  // One extra bit so a full queue can be told from an empty one
  logic [rd_split_pkg::FIFO_IDX_W:0]    count_q;

  assign full_o     = (count_q == (rd_split_pkg::FIFO_IDX_W+1)'(rd_split_pkg::MAX_RD_TXNS));
  assign empty_o    = (count_q == '0);
  assign head_len_o = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_len_i;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* r_last_stage.sv */
// Passes read beats upstream and rebuilds the last flag from the queued burst length
`timescale 1ns/1ps

module r_last_stage (
  input  logic                             clk_i,
  input  logic                             rst_i,

  // Downstream R
  input  logic [rd_split_pkg::DATA_W-1:0]  m_r_data_i,
  input  logic [rd_split_pkg::ID_W-1:0]    m_r_id_i,
  input  logic [rd_split_pkg::RESP_W-1:0]  m_r_resp_i,
  input  logic                             m_r_valid_i,
  output logic                             m_r_ready_o,

  // Upstream R
  output logic [rd_split_pkg::DATA_W-1:0]  s_r_data_o,
  output logic [rd_split_pkg::ID_W-1:0]    s_r_id_o,
  output logic [rd_split_pkg::RESP_W-1:0]  s_r_resp_o,
  output logic                             s_r_last_o,
  output logic                             s_r_valid_o,
  input  logic                             s_r_ready_i,

  // Length queue read side
  input  logic [rd_split_pkg::LEN_W-1:0]   head_len_i,
  input  logic                             fifo_empty_i,
  output logic                             pop_o
);

  // Beats of the head burst already passed upstream
  logic [rd_split_pkg::LEN_W-1:0]  beat_cnt_q;
  logic                            xfer;

  // Payload goes straight through
  assign s_r_data_o = m_r_data_i;
  assign s_r_id_o   = m_r_id_i;
  assign s_r_resp_o = m_r_resp_i;

  // Hold the handshake off until a burst length is known
  assign s_r_valid_o = m_r_valid_i & ~fifo_empty_i;
  assign m_r_ready_o = s_r_ready_i & ~fifo_empty_i;

  assign s_r_last_o = (beat_cnt_q == head_len_i);
  assign xfer       = s_r_valid_o & s_r_ready_i;

  // Head burst is finished, drop its length
  assign pop_o = xfer & s_r_last_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt_q <= '0;
    end else if (xfer) begin
      if (s_r_last_o) begin
        beat_cnt_q <= '0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

/* rd_burst_splitter.sv */
// Top level of the read burst splitter, joins AR split, length queue and R last rebuild
`timescale 1ns/1ps

module rd_burst_splitter (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Upstream AR
  input  logic [rd_split_pkg::ID_W-1:0]     ar_id_i,
  input  logic [rd_split_pkg::ADDR_W-1:0]   ar_addr_i,
  input  logic [rd_split_pkg::LEN_W-1:0]    ar_len_i,
  input  logic [rd_split_pkg::SIZE_W-1:0]   ar_size_i,
  input  logic [rd_split_pkg::BURST_W-1:0]  ar_burst_i,
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,

  // Downstream AR, single beat only
  output logic [rd_split_pkg::ID_W-1:0]     m_ar_id_o,
  output logic [rd_split_pkg::ADDR_W-1:0]   m_ar_addr_o,
  output logic                              m_ar_valid_o,
  input  logic                              m_ar_ready_i,

  // Downstream R, answered in request order
  input  logic [rd_split_pkg::DATA_W-1:0]   m_r_data_i,
  input  logic [rd_split_pkg::ID_W-1:0]     m_r_id_i,
  input  logic [rd_split_pkg::RESP_W-1:0]   m_r_resp_i,
  input  logic                              m_r_valid_i,
  output logic                              m_r_ready_o,

  // Upstream R with rebuilt last
  output logic [rd_split_pkg::DATA_W-1:0]   s_r_data_o,
  output logic [rd_split_pkg::ID_W-1:0]     s_r_id_o,
  output logic [rd_split_pkg::RESP_W-1:0]   s_r_resp_o,
  output logic                              s_r_last_o,
  output logic                              s_r_valid_o,
  input  logic                              s_r_ready_i
);

  logic                            push;
  logic [rd_split_pkg::LEN_W-1:0]  push_len;
  logic                            pop;
  logic [rd_split_pkg::LEN_W-1:0]  head_len;
  logic                            full;
  logic                            empty;

  ar_split_stage i_ar_split (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .ar_id_i      ( ar_id_i      ),
    .ar_addr_i    ( ar_addr_i    ),
    .ar_len_i     ( ar_len_i     ),
    .ar_size_i    ( ar_size_i    ),
    .ar_burst_i   ( ar_burst_i   ),
    .ar_valid_i   ( ar_valid_i   ),
    .ar_ready_o   ( ar_ready_o   ),
    .m_ar_id_o    ( m_ar_id_o    ),
    .m_ar_addr_o  ( m_ar_addr_o  ),
    .m_ar_valid_o ( m_ar_valid_o ),
    .m_ar_ready_i ( m_ar_ready_i ),
    .fifo_full_i  ( full         ),
    .push_o       ( push         ),
    .push_len_o   ( push_len     )
  );

  burst_len_fifo i_len_fifo (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .push_i       ( push         ),
    .push_len_i   ( push_len     ),
    .pop_i        ( pop          ),
    .head_len_o   ( head_len     ),
    .full_o       ( full         ),
    .empty_o      ( empty        )
  );

  r_last_stage i_r_last (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .m_r_data_i   ( m_r_data_i   ),
    .m_r_id_i     ( m_r_id_i     ),
    .m_r_resp_i   ( m_r_resp_i   ),
    .m_r_valid_i  ( m_r_valid_i  ),
    .m_r_ready_o  ( m_r_ready_o  ),
    .s_r_data_o   ( s_r_data_o   ),
    .s_r_id_o     ( s_r_id_o     ),
    .s_r_resp_o   ( s_r_resp_o   ),
    .s_r_last_o   ( s_r_last_o   ),
    .s_r_valid_o  ( s_r_valid_o  ),
    .s_r_ready_i  ( s_r_ready_i  ),
    .head_len_i   ( head_len     ),
    .fifo_empty_i ( empty        ),
    .pop_o        ( pop          )
  );

endmodule

/* rd_burst_splitter_chk.sv */
// Concurrent protocol checks that bind attaches to the read burst splitter top level
`timescale 1ns/1ps

module rd_burst_splitter_chk (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              ar_valid_i,
  input logic                              ar_ready_o,
  input logic [rd_split_pkg::ID_W-1:0]     ar_id_i,
  input logic [rd_split_pkg::ADDR_W-1:0]   ar_addr_i,
  input logic [rd_split_pkg::LEN_W-1:0]    ar_len_i,
  input logic [rd_split_pkg::SIZE_W-1:0]   ar_size_i,
  input logic [rd_split_pkg::BURST_W-1:0]  ar_burst_i,
  input logic                              m_ar_valid_o,
  input logic                              m_ar_ready_i,
  input logic [rd_split_pkg::ID_W-1:0]     m_ar_id_o,
  input logic [rd_split_pkg::ADDR_W-1:0]   m_ar_addr_o,
  input logic                              s_r_valid_o,
  input logic                              s_r_ready_i,
  input logic [rd_split_pkg::DATA_W-1:0]   s_r_data_o,
  input logic [rd_split_pkg::ID_W-1:0]     s_r_id_o,
  input logic [rd_split_pkg::RESP_W-1:0]   s_r_resp_o,
  input logic                              s_r_last_o
);

  // Bursts accepted upstream whose last beat has not gone back yet
  logic [rd_split_pkg::FIFO_IDX_W:0]  outstanding_q;
  logic                               ar_xfer;
  logic                               r_done;

  assign ar_xfer = ar_valid_i & ar_ready_o;
  assign r_done  = s_r_valid_o & s_r_ready_i & s_r_last_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
    end else begin
      case ({ar_xfer, r_done})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // WRAP has no splitting rule
  assert property (@(posedge clk_i) disable iff (rst_i)
    ar_valid_i && ar_ready_o |-> ar_burst_i != rd_split_pkg::BURST_WRAP)
    else $error("WRAP burst accepted on upstream AR");

  // ------------------------------------------------------------------------
  // Valid and payload held until the transfer
  // ------------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (rst_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i &&
      $stable({ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i}))
    else $error("upstream AR request changed before acceptance");

  assert property (@(posedge clk_i) disable iff (rst_i)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable({m_ar_id_o, m_ar_addr_o}))
    else $error("single-beat request changed before transfer");

  assert property (@(posedge clk_i) disable iff (rst_i)
    s_r_valid_o && !s_r_ready_i |=> s_r_valid_o &&
      $stable({s_r_data_o, s_r_id_o, s_r_resp_o, s_r_last_o}))
    else $error("upstream R beat changed before transfer");

  // Read data only while an accepted burst still waits for its last beat
  assert property (@(posedge clk_i) disable iff (rst_i) s_r_valid_o |-> outstanding_q != '0)
    else $error("upstream R valid with no burst outstanding");

endmodule

bind rd_burst_splitter rd_burst_splitter_chk chk0 (.*);

/* tb_rd_burst_splitter.sv */
// Table-driven testbench for the read burst splitter and top module of the simulation build
`timescale 1ns/1ps

module tb_rd_burst_splitter;

  localparam int NUM_TESTS = 8;

  logic                              clk_i = 1'b0;
  logic                              rst_i = 1'b1;
  logic [rd_split_pkg::ID_W-1:0]     ar_id_i = '0;
  logic [rd_split_pkg::ADDR_W-1:0]   ar_addr_i = '0;
  logic [rd_split_pkg::LEN_W-1:0]    ar_len_i = '0;
  logic [rd_split_pkg::SIZE_W-1:0]   ar_size_i = '0;
  logic [rd_split_pkg::BURST_W-1:0]  ar_burst_i = '0;
  logic                              ar_valid_i = 1'b0;
  logic                              ar_ready_o;
  logic [rd_split_pkg::ID_W-1:0]     m_ar_id_o;
  logic [rd_split_pkg::ADDR_W-1:0]   m_ar_addr_o;
  logic                              m_ar_valid_o;
  logic                              m_ar_ready_i = 1'b0;
  logic [rd_split_pkg::DATA_W-1:0]   m_r_data_i = '0;
  logic [rd_split_pkg::ID_W-1:0]     m_r_id_i = '0;
  logic [rd_split_pkg::RESP_W-1:0]   m_r_resp_i = '0;
  logic                              m_r_valid_i = 1'b0;
  logic                              m_r_ready_o;
  logic [rd_split_pkg::DATA_W-1:0]   s_r_data_o;
  logic [rd_split_pkg::ID_W-1:0]     s_r_id_o;
  logic [rd_split_pkg::RESP_W-1:0]   s_r_resp_o;
  logic                              s_r_last_o;
  logic                              s_r_valid_o;
  logic                              s_r_ready_i = 1'b0;

  // One row of stimulus and expected values per burst
  string                             t_name  [NUM_TESTS];
  logic [rd_split_pkg::ID_W-1:0]     t_id    [NUM_TESTS];
  logic [rd_split_pkg::ADDR_W-1:0]   t_addr  [NUM_TESTS];
  logic [rd_split_pkg::LEN_W-1:0]    t_len   [NUM_TESTS];
  logic [rd_split_pkg::SIZE_W-1:0]   t_size  [NUM_TESTS];
  logic [rd_split_pkg::BURST_W-1:0]  t_burst [NUM_TESTS];
  int                                t_beats [NUM_TESTS];
  logic [rd_split_pkg::ADDR_W-1:0]   t_final [NUM_TESTS];

  // Requests in the memory model still waiting for their read beat
  logic [rd_split_pkg::ADDR_W-1:0]   req_addr_q [$];
  logic [rd_split_pkg::ID_W-1:0]     req_id_q [$];
  logic                              r_pending = 1'b0;
  logic [31:0]                       lfsr = 32'h0974_57cc;

  int cycle_cnt = 0;
  int cycle_limit = 0;
  int ar_sent = 0;
  int rx_row = 0;
  int rx_beat = 0;
  int row_errs = 0;
  int err_cnt = 0;
  int rows_ok = 0;
  int rows_bad = 0;
  int reset_errs = 0;

  rd_burst_splitter dut0 (.*);

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic set_row(input int idx, input string name, input int id,
                         input logic [31:0] addr, input int len, input int size,
                         input logic [1:0] burst, input int beats, input logic [31:0] fin);
    t_name[idx]  = name;
    t_id[idx]    = rd_split_pkg::ID_W'(id);
    t_addr[idx]  = addr;
    t_len[idx]   = rd_split_pkg::LEN_W'(len);
    t_size[idx]  = rd_split_pkg::SIZE_W'(size);
    t_burst[idx] = burst;
    t_beats[idx] = beats;
    t_final[idx] = fin;
  endtask

  // ------------------------------------------------------------------------
  // Upstream R checking
  // ------------------------------------------------------------------------
  task automatic close_row();
    assert (rx_beat == t_beats[rx_row]) else begin
      $display("ERR %s beat count: expected %0d, actual %0d", t_name[rx_row],
               t_beats[rx_row], rx_beat);
      row_errs++;
    end
    assert (s_r_data_o == t_final[rx_row]) else begin
      $display("ERR %s final address: expected %h, actual %h", t_name[rx_row],
               t_final[rx_row], s_r_data_o);
      row_errs++;
    end
    if (row_errs == 0) begin
      $display("%s: ok, %0d beats", t_name[rx_row], rx_beat);
      rows_ok++;
    end else begin
      $display("%s: %0d wrong values", t_name[rx_row], row_errs);
      rows_bad++;
    end
    err_cnt += row_errs;
    row_errs = 0;
    rx_beat = 0;
    rx_row++;
  endtask

  task automatic check_r_beat();
    logic [rd_split_pkg::ADDR_W-1:0] exp_addr;
    logic                            exp_last;
    exp_addr = t_addr[rx_row];
    // INCR steps by the beat size and FIXED stays put
    if (t_burst[rx_row] == rd_split_pkg::BURST_INCR) begin
      exp_addr = exp_addr + (rd_split_pkg::ADDR_W'(rx_beat) << t_size[rx_row]);
    end
    exp_last = (rx_beat == int'(t_len[rx_row]));
    assert (s_r_data_o == exp_addr) else begin
      $display("ERR %s beat %0d data: expected %h, actual %h", t_name[rx_row], rx_beat,
               exp_addr, s_r_data_o);
      row_errs++;
    end
    assert (s_r_id_o == t_id[rx_row]) else begin
      $display("ERR %s beat %0d id: expected %h, actual %h", t_name[rx_row], rx_beat,
               t_id[rx_row], s_r_id_o);
      row_errs++;
    end
    assert (s_r_resp_o == '0) else begin
      $display("ERR %s beat %0d resp: expected 0, actual %h", t_name[rx_row], rx_beat,
               s_r_resp_o);
      row_errs++;
    end
    assert (s_r_last_o == exp_last) else begin
      $display("ERR %s beat %0d last: expected %b, actual %b", t_name[rx_row], rx_beat,
               exp_last, s_r_last_o);
      row_errs++;
    end
    rx_beat++;
    if (s_r_last_o) begin
      close_row();
    end
  endtask

  // ------------------------------------------------------------------------
  // Outputs are sampled on the rising edge while inputs change on the falling edge
  // ------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycle_cnt++;
      if (ar_valid_i && ar_ready_o) begin
        ar_sent++;
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        req_addr_q.push_back(m_ar_addr_o);
        req_id_q.push_back(m_ar_id_o);
      end
      if (m_r_valid_i && m_r_ready_o) begin
        req_addr_q.delete(0);
        req_id_q.delete(0);
        r_pending = 1'b0;
      end
      if (s_r_valid_o && s_r_ready_i && rx_row < NUM_TESTS) begin
        check_r_beat();
      end
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout after %0d cycles, %0d of %0d bursts complete", cycle_cnt, rx_row,
                 NUM_TESTS);
        if (rx_row < NUM_TESTS) begin
          $display("burst %s is missing beats, %0d of %0d returned", t_name[rx_row], rx_beat,
                   t_beats[rx_row]);
        end
        $display("test failed");
        $finish;
      end
    end
  end

  // Random back-pressure and in-order answers from the memory model
  always @(negedge clk_i) begin
    lfsr = lfsr_step(lfsr);
    m_ar_ready_i = lfsr[0];
    lfsr = lfsr_step(lfsr);
    s_r_ready_i = lfsr[0];
    if (!r_pending && req_addr_q.size() > 0) begin
      lfsr = lfsr_step(lfsr);
      if (lfsr[0]) begin
        r_pending = 1'b1;
        m_r_data_i = req_addr_q[0];
        m_r_id_i = req_id_q[0];
      end
    end
    m_r_valid_i = r_pending;
  end

  initial begin
    int total_ok;
    int total_bad;
    //          name        id  start addr      len size burst                     beats final
    set_row(0, "incr_w4",   1, 32'h0000_1000,  3, 2, rd_split_pkg::BURST_INCR,  4, 32'h0000_100c);
    set_row(1, "fixed_5",   2, 32'h2000_0040,  4, 2, rd_split_pkg::BURST_FIXED, 5, 32'h2000_0040);
    set_row(2, "single",    3, 32'h0000_3008,  0, 2, rd_split_pkg::BURST_INCR,  1, 32'h0000_3008);
    set_row(3, "incr_b8",   4, 32'h4000_0001,  7, 0, rd_split_pkg::BURST_INCR,  8, 32'h4000_0008);
    set_row(4, "incr_d3",   5, 32'h5000_0000,  2, 3, rd_split_pkg::BURST_INCR,  3, 32'h5000_0010);
    set_row(5, "fixed_2",   6, 32'h6000_0010,  1, 1, rd_split_pkg::BURST_FIXED, 2, 32'h6000_0010);
    set_row(6, "incr_w16",  7, 32'h7000_0100, 15, 2, rd_split_pkg::BURST_INCR, 16, 32'h7000_013c);
    set_row(7, "single_f",  8, 32'h8000_0004,  0, 2, rd_split_pkg::BURST_FIXED, 1, 32'h8000_0004);
    cycle_limit = 200;
    for (int i = 0; i < NUM_TESTS; i++) begin
      cycle_limit += 8 * t_beats[i];
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    assert (ar_ready_o === 1'b1 && m_ar_valid_o === 1'b0 && s_r_valid_o === 1'b0) else begin
      $display("ERR reset_state ar_ready/m_ar_valid/s_r_valid: expected 100, actual %b%b%b",
               ar_ready_o, m_ar_valid_o, s_r_valid_o);
      reset_errs++;
    end
    $display("reset_state: %s", (reset_errs == 0) ? "ok" : "wrong values");
    rst_i = 1'b0;
    // Bursts go out back to back and each is held until accepted
    for (int i = 0; i < NUM_TESTS; i++) begin
      ar_id_i    = t_id[i];
      ar_addr_i  = t_addr[i];
      ar_len_i   = t_len[i];
      ar_size_i  = t_size[i];
      ar_burst_i = t_burst[i];
      ar_valid_i = 1'b1;
      do begin
        @(negedge clk_i);
      end while (ar_sent <= i);
    end
    ar_valid_i = 1'b0;
    wait (rx_row == NUM_TESTS);
    @(negedge clk_i);
    // Every single-beat request must have been answered once all bursts are back
    assert (req_addr_q.size() == 0 && m_ar_valid_o === 1'b0) else begin
      $display("downstream requests left over after the last burst: %0d queued, valid %b",
               req_addr_q.size(), m_ar_valid_o);
      err_cnt++;
    end
    total_ok  = rows_ok + ((reset_errs == 0) ? 1 : 0);
    total_bad = rows_bad + ((reset_errs == 0) ? 0 : 1);
    $display("summary: %0d tests, %0d ok, %0d with errors, %0d wrong values", NUM_TESTS + 1,
             total_ok, total_bad, err_cnt + reset_errs);
    if (total_bad == 0 && err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* all.f */
rd_split_pkg.sv
ar_split_stage.sv
burst_len_fifo.sv
r_last_stage.sv
rd_burst_splitter.sv
rd_burst_splitter_chk.sv
tb_rd_burst_splitter.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rd_burst_splitter
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
